// File: design/gfx_isa_pkg.sv
package gfx_isa_pkg;

	localparam int lanes = 4;
	localparam int lane_w = 16;
	localparam int vreg_idx_w = 3;
	localparam int lane_sel_w = $clog2(lanes); // Swizzle source lane index.

	typedef logic [31:0] insn_word;
	typedef logic [lanes-1:0][lane_w-1:0] vector;

	typedef enum logic [2:0] {
		op_select = 3'd0,
		op_swizzl = 3'd1,
		op_broadc = 3'd2,
		op_matvec = 3'd3,
		op_send   = 3'd4,
		op_recv   = 3'd5
	} opcode_e;

	// Field positions in the instruction word
	localparam int op_hi = 31;
	localparam int op_lo = 29;

	localparam int dst_hi = 28;
	localparam int dst_lo = 26;

	localparam int src_a_hi = 25;
	localparam int src_a_lo = 23;

	localparam int src_b_hi = 22;
	localparam int src_b_lo = 20;

	localparam int select_mask_hi = 19; // One bit per lane.
	localparam int select_mask_lo = 16;

	localparam int broadc_imm_hi = 15;
	localparam int broadc_imm_lo = 0;

	localparam int swizzl_lanes_hi = 7; // Lane 0 selector in the low bits.
	localparam int swizzl_lanes_lo = 0;

endpackage

// File: design/gfx_sp_pkg.sv
package gfx_sp_pkg;

	import gfx_isa_pkg::*;

	localparam int nregs = 8;

	typedef struct packed {
		logic stream;
		logic shuffler;
	} ex_unit_t;

	typedef struct packed {
		logic                        is_imm;
		logic                        is_swizzle;
		logic [lane_w-1:0]           imm;
		logic [lanes-1:0]            select_mask;
		logic [lanes*lane_sel_w-1:0] swizzle_op;
	} shuffler_t;

	typedef struct packed {
		logic                  writeback;
		logic                  read_src_a;
		logic                  read_src_b;
		ex_unit_t              ex;
		shuffler_t             shuffler;
		logic [vreg_idx_w-1:0] dst;
		logic [vreg_idx_w-1:0] src_a;
		logic [vreg_idx_w-1:0] src_b;
		logic                  clear_lanes;
		logic                  illegal;
	} insn_deco;

	// Operand stage output, decoded insn plus source values.
	typedef struct packed {
		insn_deco deco;
		vector    val_a;
		vector    val_b;
	} operand_t;

endpackage

// File: design/gfx_regfile_if.sv
`timescale 1ns/1ps

interface gfx_regfile_if
	import gfx_isa_pkg::*;
();

	logic [vreg_idx_w-1:0] rd_idx_a;
	logic [vreg_idx_w-1:0] rd_idx_b;
	vector                 rd_data_a;
	vector                 rd_data_b;

	logic                  wr_en;
	logic [vreg_idx_w-1:0] wr_idx;
	vector                 wr_data;

	modport file (
		input  rd_idx_a, rd_idx_b, wr_en, wr_idx, wr_data,
		output rd_data_a, rd_data_b
	);

	// Reader also watches writes to retire pending bits.
	modport reader (
		output rd_idx_a, rd_idx_b,
		input  rd_data_a, rd_data_b, wr_en, wr_idx
	);

	modport writer (
		output wr_en, wr_idx, wr_data
	);

endinterface

// File: design/gfx_skid_buf.sv
`timescale 1ns/1ps

module gfx_skid_buf #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic arst_n,

	input  T     in,
	input  logic in_valid,
	output logic in_ready,

	output T     out,
	output logic out_valid,
	input  logic out_ready
);

	T     main_q, skid_q;
	logic main_valid, skid_valid;
	logic advance;

	assign advance = out_ready || !main_valid; // Main slot frees up this cycle.

	assign in_ready = !skid_valid;
	assign out = main_q;
	assign out_valid = main_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (advance) begin
			main_valid <= skid_valid || in_valid;
			skid_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			skid_valid <= 1'b1; // Main is stalled, park the new item.
		end
	end

	always_ff @(posedge clk) begin
		if (advance)
			main_q <= skid_valid ? skid_q : in;
		else if (in_valid && in_ready)
			skid_q <= in;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

// File: design/gfx_sp_decode.sv
`timescale 1ns/1ps

module gfx_sp_decode
	import gfx_isa_pkg::*;
	import gfx_sp_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,

	input  logic     clear_lanes,
	input  insn_word insn,
	input  logic     insn_valid,
	output logic     insn_ready,

	output insn_deco deco,
	output logic     deco_valid,
	input  logic     deco_ready
);

	opcode_e  op;
	insn_deco deco_in;

	assign op = opcode_e'(insn[op_hi:op_lo]);

	always_comb begin
		deco_in.writeback = 1'b0;
		deco_in.read_src_a = 1'b0;
		deco_in.read_src_b = 1'b0;
		deco_in.ex.stream = 1'b0;
		deco_in.ex.shuffler = 1'b0;
		deco_in.shuffler.is_imm = 1'b0;
		deco_in.shuffler.is_swizzle = 1'b0;
		deco_in.illegal = 1'b0;

		case (op)
			op_select: begin
				deco_in.writeback = 1'b1;
				deco_in.read_src_a = 1'b1;
				deco_in.read_src_b = 1'b1;
				deco_in.ex.shuffler = 1'b1;
			end
			op_swizzl: begin
				deco_in.writeback = 1'b1;
				deco_in.read_src_a = 1'b1;
				deco_in.ex.shuffler = 1'b1;
				deco_in.shuffler.is_swizzle = 1'b1;
			end
			op_broadc: begin
				deco_in.writeback = 1'b1;
				deco_in.ex.shuffler = 1'b1;
				deco_in.shuffler.is_imm = 1'b1;
			end
			op_send: begin
				deco_in.read_src_a = 1'b1; // Vector goes out as is.
				deco_in.ex.stream = 1'b1;
			end
			op_recv: begin
				deco_in.writeback = 1'b1;
				deco_in.ex.stream = 1'b1;
			end
			op_matvec: deco_in.illegal = 1'b1; // No combiner in this core.
			default:   deco_in.illegal = 1'b1;
		endcase

		deco_in.dst = insn[dst_hi:dst_lo];
		deco_in.src_a = insn[src_a_hi:src_a_lo];
		deco_in.src_b = insn[src_b_hi:src_b_lo];
		deco_in.clear_lanes = clear_lanes;

		deco_in.shuffler.imm = insn[broadc_imm_hi:broadc_imm_lo];
		deco_in.shuffler.select_mask = insn[select_mask_hi:select_mask_lo];
		deco_in.shuffler.swizzle_op = insn[swizzl_lanes_hi:swizzl_lanes_lo];
	end

	gfx_skid_buf #(.T(insn_deco)) u_skid (
		.clk       (clk),
		.arst_n    (arst_n),
		.in        (deco_in),
		.in_valid  (insn_valid),
		.in_ready  (insn_ready),
		.out       (deco),
		.out_valid (deco_valid),
		.out_ready (deco_ready)
	);

endmodule

// File: design/gfx_sp_regs.sv
`timescale 1ns/1ps

module gfx_sp_regs
	import gfx_sp_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,

	input  insn_deco      deco,
	input  logic          deco_valid,
	output logic          deco_ready,

	gfx_regfile_if.reader rf,

	output operand_t      opnd,
	output logic          opnd_valid,
	input  logic          opnd_ready
);

	logic [nregs-1:0] pending; // Registers with a write in flight.
	logic             stall;
	logic             skid_ready;
	logic             accept;
	operand_t         opnd_in;

	assign rf.rd_idx_a = deco.src_a;
	assign rf.rd_idx_b = deco.src_b;

	// Hold on RAW and WAW hazards.
	assign stall = (deco.read_src_a && pending[deco.src_a])
		|| (deco.read_src_b && pending[deco.src_b])
		|| (deco.writeback && pending[deco.dst]);

	assign deco_ready = skid_ready && !stall;
	assign accept = deco_valid && deco_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
		end else begin
			if (rf.wr_en)
				pending[rf.wr_idx] <= 1'b0;
			if (accept && deco.writeback)
				pending[deco.dst] <= 1'b1; // Never the index being retired.
		end
	end

	always_comb begin
		opnd_in.deco = deco;
		opnd_in.val_a = rf.rd_data_a;
		opnd_in.val_b = rf.rd_data_b;
	end

	gfx_skid_buf #(.T(operand_t)) u_skid (
		.clk       (clk),
		.arst_n    (arst_n),
		.in        (opnd_in),
		.in_valid  (deco_valid && !stall),
		.in_ready  (skid_ready),
		.out       (opnd),
		.out_valid (opnd_valid),
		.out_ready (opnd_ready)
	);

	// Exec only writes what this stage marked.
	assert property (@(posedge clk) disable iff (!arst_n)
		rf.wr_en |-> pending[rf.wr_idx]);

endmodule

// File: design/gfx_regfile.sv
`timescale 1ns/1ps

module gfx_regfile
	import gfx_isa_pkg::*;
	import gfx_sp_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,

	gfx_regfile_if.file rf
);

	vector regs [nregs];

	// Old value on a same-cycle read and write.
	assign rf.rd_data_a = regs[rf.rd_idx_a];
	assign rf.rd_data_b = regs[rf.rd_idx_b];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (rf.wr_en) begin
			regs[rf.wr_idx] <= rf.wr_data;
		end
	end

endmodule

// File: design/gfx_sp_exec.sv
`timescale 1ns/1ps

module gfx_sp_exec
	import gfx_isa_pkg::*;
	import gfx_sp_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,

	input  operand_t      opnd,
	input  logic          opnd_valid,
	output logic          opnd_ready,

	gfx_regfile_if.writer rf,

	output vector         send_data,
	output logic          send_valid,
	input  logic          send_ready,

	input  vector         recv_data,
	input  logic          recv_valid,
	output logic          recv_ready
);

	insn_deco d;
	logic     is_send, is_recv;
	logic     done;
	vector    shuf_res;
	vector    raw_res;
	vector    wb_data;

	assign d = opnd.deco;

	// Stream insns are told apart by writeback.
	assign is_send = d.ex.stream && !d.writeback;
	assign is_recv = d.ex.stream && d.writeback;

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			if (d.shuffler.is_imm)
				shuf_res[i] = d.shuffler.imm;
			else if (d.shuffler.is_swizzle)
				shuf_res[i] = opnd.val_a[d.shuffler.swizzle_op[i*lane_sel_w +: lane_sel_w]];
			else
				shuf_res[i] = d.shuffler.select_mask[i] ? opnd.val_a[i] : opnd.val_b[i];
		end
	end

	assign raw_res = is_recv ? recv_data : shuf_res;

	always_comb begin
		for (int i = 0; i < lanes; i++)
			wb_data[i] = (d.clear_lanes && !d.shuffler.select_mask[i]) ? '0 : raw_res[i];
	end

	assign send_data = opnd.val_a;
	assign send_valid = opnd_valid && is_send;
	assign recv_ready = opnd_valid && is_recv;

	always_comb begin
		if (is_send)
			done = send_ready;
		else if (is_recv)
			done = recv_valid;
		else
			done = 1'b1; // Shuffler and illegal retire at once.
	end

	assign opnd_ready = done;

	assign rf.wr_en = opnd_valid && done && d.writeback;
	assign rf.wr_idx = d.dst;
	assign rf.wr_data = wb_data;

	// Decode must pick exactly one unit.
	assert property (@(posedge clk) disable iff (!arst_n)
		opnd_valid && !d.illegal |-> $onehot({d.ex.stream, d.ex.shuffler}));

endmodule

// File: design/gfx_sp_core.sv
`timescale 1ns/1ps

module gfx_sp_core
	import gfx_isa_pkg::*;
	import gfx_sp_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,

	input  logic     clear_lanes,
	input  insn_word insn,
	input  logic     insn_valid,
	output logic     insn_ready,

	output vector    send_data,
	output logic     send_valid,
	input  logic     send_ready,

	input  vector    recv_data,
	input  logic     recv_valid,
	output logic     recv_ready
);

	insn_deco deco;
	logic     deco_valid, deco_ready;
	operand_t opnd;
	logic     opnd_valid, opnd_ready;

	gfx_regfile_if rf_if();

	gfx_sp_decode u_decode (
		.clk         (clk),
		.arst_n      (arst_n),
		.clear_lanes (clear_lanes),
		.insn        (insn),
		.insn_valid  (insn_valid),
		.insn_ready  (insn_ready),
		.deco        (deco),
		.deco_valid  (deco_valid),
		.deco_ready  (deco_ready)
	);

	gfx_sp_regs u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.deco       (deco),
		.deco_valid (deco_valid),
		.deco_ready (deco_ready),
		.rf         (rf_if.reader),
		.opnd       (opnd),
		.opnd_valid (opnd_valid),
		.opnd_ready (opnd_ready)
	);

	gfx_regfile u_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.rf     (rf_if.file)
	);

	gfx_sp_exec u_exec (
		.clk        (clk),
		.arst_n     (arst_n),
		.opnd       (opnd),
		.opnd_valid (opnd_valid),
		.opnd_ready (opnd_ready),
		.rf         (rf_if.writer),
		.send_data  (send_data),
		.send_valid (send_valid),
		.send_ready (send_ready),
		.recv_data  (recv_data),
		.recv_valid (recv_valid),
		.recv_ready (recv_ready)
	);

endmodule

// File: include/gfx_sp_ref.svh
`ifndef gfx_sp_ref_svh
`define gfx_sp_ref_svh

vector gold_regs [8] = '{default: '0}; // Golden register file.

// Updates gold_regs for one instruction, returns 1 for a send.
function automatic logic ref_exec(input insn_word w, input logic cl, input vector rv,
		output vector exp_send);
	logic [2:0] op;
	logic [3:0] mask;
	vector      a;
	vector      b;
	vector      res;
	logic       wr;
	op = w[31:29];
	mask = w[19:16];
	a = gold_regs[w[25:23]];
	b = gold_regs[w[22:20]];
	exp_send = a;
	res = '0;
	wr = 1'b1;
	case (op)
		3'd0: for (int i = 0; i < 4; i++)
			res[i] = mask[i] ? a[i] : b[i];
		3'd1: for (int i = 0; i < 4; i++)
			res[i] = a[w[2*i +: 2]];
		3'd2: for (int i = 0; i < 4; i++)
			res[i] = w[15:0];
		3'd5: res = rv;
		default: wr = 1'b0; // Send, matvec and unused.
	endcase
	if (wr) begin
		for (int i = 0; i < 4; i++)
			if (cl && !mask[i])
				res[i] = '0;
		gold_regs[w[28:26]] = res;
	end
	return op == 3'd4;
endfunction

`endif

// File: verification/gfx_sp_tb.sv
`timescale 1ns/1ps

module gfx_sp_tb
	import gfx_isa_pkg::*;
	import gfx_sp_pkg::*;
();

	localparam int timeout_cycles = 2000;

	logic     clk, arst_n, clear_lanes;
	insn_word insn;
	logic     insn_valid, insn_ready;
	vector    send_data, recv_data;
	logic     send_valid, send_ready, recv_valid, recv_ready;
	logic     bp_on;
	string    test_name;
	vector    exp_q[$]; // Expected send vectors in order.
	vector    recv_q[$];

	`include "gfx_sp_ref.svh"

	gfx_sp_core u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic compare_vector(input string name, input vector exp, input vector act);
		if (act !== exp)
			fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic compare_ready_after_reset(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic vector random_vector();
		vector       v;
		logic [31:0] r;
		for (int i = 0; i < lanes; i++) begin
			r = $urandom();
			v[i] = r[15:0];
		end
		return v;
	endfunction

	function automatic insn_word make_insn(input logic [2:0] op, input logic [2:0] dst,
			input logic [2:0] sa, input logic [2:0] sb, input logic [19:0] low);
		return {op, dst, sa, sb, low};
	endfunction

	function automatic logic [2:0] legal_op(input logic [2:0] x);
		case (x)
			3'd3: return 3'd0;
			3'd6: return 3'd1;
			3'd7: return 3'd2;
			default: return x;
		endcase
	endfunction

	// Drives one instruction and holds it until accepted.
	task automatic issue(input insn_word w, input logic cl);
		vector       rv;
		vector       exp;
		int unsigned waited;
		rv = random_vector();
		if (w[31:29] == 3'd5)
			recv_q.push_back(rv);
		if (ref_exec(w, cl, rv, exp))
			exp_q.push_back(exp);
		insn = w;
		clear_lanes = cl;
		insn_valid = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > timeout_cycles)
				fail_run($sformatf("timeout waiting for insn_ready in %s", test_name));
		end while (!insn_ready);
		@(posedge clk);
		#1;
		insn_valid = 1'b0;
	endtask

	task automatic send_all_regs();
		for (int r = 0; r < nregs; r++)
			issue(make_insn(3'd4, 3'd0, 3'(r), 3'd0, 20'd0), 1'b0);
	endtask

	initial begin
		send_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			send_ready = bp_on ? ($urandom_range(0, 1) != 0) : 1'b1;
		end
	end

	// Offers queued vectors with random gaps.
	initial begin
		int unsigned waited;
		recv_valid = 1'b0;
		recv_data = '0;
		forever begin
			@(posedge clk);
			#1;
			if (arst_n && recv_q.size() > 0 && $urandom_range(0, 2) == 0) begin
				recv_data = recv_q.pop_front();
				recv_valid = 1'b1;
				waited = 0;
				do begin
					@(negedge clk);
					waited++;
					if (waited > timeout_cycles)
						fail_run("timeout waiting for recv_ready");
				end while (!recv_ready);
				@(posedge clk);
				#1;
				recv_valid = 1'b0;
			end
		end
	end

	// Compares every send transfer with the oldest expectation.
	initial begin
		vector exp;
		int    n_sent;
		n_sent = 0;
		forever begin
			@(negedge clk);
			if (arst_n && send_valid && send_ready) begin
				if (exp_q.size() == 0) begin
					fail_run("send transfer with no expected vector");
				end else begin
					exp = exp_q.pop_front();
					compare_vector($sformatf("%s send %0d", test_name, n_sent), exp, send_data);
					n_sent++;
				end
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [2:0]  d;
		logic [2:0]  prev;
		int unsigned waited;
		void'($urandom(32'h70f8ee63));
		arst_n = 1'b0;
		clear_lanes = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		bp_on = 1'b0;
		test_name = "reset";
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		compare_ready_after_reset("reset send_valid", 1'b0, send_valid);
		compare_ready_after_reset("reset recv_ready", 1'b0, recv_ready);
		send_all_regs();

		test_name = "broadcast";
		for (int k = 0; k < nregs; k++) begin
			r = $urandom();
			issue(make_insn(3'd2, 3'(k), 3'd0, 3'd0, {4'hf, r[15:0]}), 1'b0);
			issue(make_insn(3'd4, 3'd0, 3'(k), 3'd0, 20'd0), 1'b0);
		end

		test_name = "shuffle chain";
		prev = 3'd0;
		for (int k = 0; k < 40; k++) begin
			r = $urandom();
			d = r[2:0];
			issue(make_insn(r[3] ? 3'd1 : 3'd0, d, prev, r[6:4], r[27:8]), r[28]);
			prev = d;
			if (k % 4 == 3)
				issue(make_insn(3'd4, 3'd0, d, 3'd0, 20'd0), 1'b0);
		end
		send_all_regs();

		test_name = "recv round trip";
		for (int k = 0; k < 20; k++) begin
			r = $urandom();
			issue(make_insn(3'd5, r[2:0], 3'd0, 3'd0, r[27:8]), r[28]);
			issue(make_insn(3'd4, 3'd0, r[2:0], 3'd0, 20'd0), 1'b0);
		end

		test_name = "back pressure";
		bp_on = 1'b1;
		for (int k = 0; k < 60; k++) begin
			r = $urandom();
			issue(make_insn(legal_op(r[2:0]), {1'b0, r[4:3]}, {1'b0, r[6:5]}, {1'b0, r[8:7]},
				r[28:9]), r[29]);
		end
		send_all_regs();
		bp_on = 1'b0;

		test_name = "illegal mix";
		for (int k = 0; k < 30; k++) begin
			r = $urandom();
			if (r[31])
				issue(make_insn(r[30] ? 3'd3 : {2'b11, r[29]}, r[2:0], r[5:3], r[8:6],
					r[28:9]), r[0]);
			else
				issue(make_insn(legal_op(r[2:0]), r[5:3], r[8:6], r[11:9], r[28:9]), r[12]);
		end
		send_all_regs();

		test_name = "drain";
		waited = 0;
		while (exp_q.size() != 0 && waited <= timeout_cycles) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			fail_run("timeout with expected send vectors left over at the end");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// File: gfx_sp_core.f
+incdir+include
design/gfx_isa_pkg.sv
design/gfx_sp_pkg.sv
design/gfx_regfile_if.sv
design/gfx_skid_buf.sv
design/gfx_sp_decode.sv
design/gfx_sp_regs.sv
design/gfx_regfile.sv
design/gfx_sp_exec.sv
design/gfx_sp_core.sv
verification/gfx_sp_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module gfx_sp_tb -Mdir obj_dir -f gfx_sp_core.f; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vgfx_sp_tb)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
